//--- fpc_cfg.svh
// Shared constants for the paired-single cluster.
// Latency is fixed by the two register stages in every lane.
`ifndef FPC_CFG_SVH
`define FPC_CFG_SVH

// ---------------------------------------------------------------------------
// pipeline shape
// ---------------------------------------------------------------------------
`define FPC_LAT 2
`define FPC_LANES 3
`define FPC_CVT_LANE 2

// ---------------------------------------------------------------------------
// result encodings
// ---------------------------------------------------------------------------
`define FPC_QNAN 32'h7fc0_0000
`define FPC_INT_MIN 32'h8000_0000
`define FPC_INT_MAX 32'h7fff_ffff

`endif

//--- fpc_pkg.sv
// Types shared by the cluster lanes and the conversion path.
// An operand word is either two floats or two signed integers.
`default_nettype none

package fpc_pkg;

  typedef enum logic [2:0] {
    fop_min   = 3'd0,
    fop_max   = 3'd1,
    fop_abs   = 3'd2,
    fop_neg   = 3'd3,
    fop_cmplt = 3'd4,
    fop_pcvt  = 3'd5
  } fp_op_e;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] man;
  } fp32_s;

  typedef struct packed {
    fp32_s hi;
    fp32_s lo;
  } fp_pair_s;

  typedef struct packed {
    logic signed [31:0] ihi;
    logic signed [31:0] ilo;
  } int_pair_s;

  // float view in, integer view out of the converters.
  typedef union packed {
    fp_pair_s  fv;
    int_pair_s iv;
  } fp_word_u;

  typedef struct packed {
    logic invalid;
    logic inexact;
  } fp_flags_s;

  typedef struct packed {
    logic     valid;
    fp_op_e   op;
    fp_word_u a;
    fp_word_u b;
  } lane_req_s;

  typedef struct packed {
    logic      valid;
    fp_word_u  res;
    fp_flags_s flags;
  } lane_rsp_s;

endpackage

`default_nettype wire

//--- fp_lane.sv
// Two-stage paired-single lane: min, max, abs, neg and less-than compare.
// Takes one request per cycle with no stall; denormals order as tiny values.
`timescale 1ns/100ps
`default_nettype none
`include "fpc_cfg.svh"

module fp_lane import fpc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  lane_req_s req,
  output lane_rsp_s rsp
);

  logic       s1_valid;
  fp_op_e     s1_op;
  fp_word_u   s1_a;
  fp_word_u   s1_b;
  logic [1:0] s1_lt;   // bit 1 is the hi half.
  logic [1:0] s1_nan;
  fp32_s      res_hi;
  fp32_s      res_lo;
  fp_flags_s  flg_hi;
  fp_flags_s  flg_lo;
  logic       rsp_valid;
  fp_word_u   rsp_res;
  fp_flags_s  rsp_flags;

  function automatic logic is_nan(input fp32_s x);
    return (x.exp == 8'hff) && (x.man != '0);
  endfunction

  // sign-magnitude order, -0 sits below +0.
  function automatic logic sm_less(input fp32_s x, input fp32_s y);
    logic less;
    if (x.sign != y.sign) begin
      less = x.sign;
    end else if (x.sign) begin
      less = {x.exp, x.man} > {y.exp, y.man};
    end else begin
      less = {x.exp, x.man} < {y.exp, y.man};
    end
    return less;
  endfunction

  function automatic void pick(input fp_op_e op, input fp32_s x, input fp32_s y,
                               input logic lt, input logic nan,
                               output fp32_s r, output fp_flags_s f);
    r = x;
    f = '0;
    case (op)
      fop_min, fop_max: begin
        if (nan) begin
          r         = `FPC_QNAN;
          f.invalid = 1'b1;
        end else if ((op == fop_min) != lt) begin
          r = y;
        end
      end
      fop_abs:   r.sign = 1'b0;
      fop_neg:   r.sign = ~x.sign;
      fop_cmplt: begin
        r         = (lt && !nan) ? '1 : '0;
        f.invalid = nan;
      end
      default: begin
        r         = '0;   // pcvt and unused codes.
        f.invalid = 1'b1;
      end
    endcase
  endfunction

  // ---------------------------------------------------------------------------
  // stage 1: classify and order
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    s1_op  <= req.op;
    s1_a   <= req.a;
    s1_b   <= req.b;
    s1_lt  <= {sm_less(req.a.fv.hi, req.b.fv.hi), sm_less(req.a.fv.lo, req.b.fv.lo)};
    s1_nan <= {is_nan(req.a.fv.hi) | is_nan(req.b.fv.hi),
               is_nan(req.a.fv.lo) | is_nan(req.b.fv.lo)};
  end

  // ---------------------------------------------------------------------------
  // stage 2: select per half
  // ---------------------------------------------------------------------------
  always_comb begin
    pick(s1_op, s1_a.fv.hi, s1_b.fv.hi, s1_lt[1], s1_nan[1], res_hi, flg_hi);
    pick(s1_op, s1_a.fv.lo, s1_b.fv.lo, s1_lt[0], s1_nan[0], res_lo, flg_lo);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      rsp_valid <= 1'b0;
      rsp_flags <= '0;
    end else begin
      s1_valid  <= req.valid;
      rsp_valid <= s1_valid;
      rsp_flags <= s1_valid ? (flg_hi | flg_lo) : '0;
    end
  end

  always_ff @(posedge clk) begin
    rsp_res.fv.hi <= res_hi;
    rsp_res.fv.lo <= res_lo;
  end

  assign rsp = '{valid: rsp_valid, res: rsp_res, flags: rsp_flags};

endmodule

`default_nettype wire

//--- fp_to_int.sv
// Two-stage float32 to signed int32 conversion, truncating toward zero.
// NaN and out-of-range values saturate with invalid; -2^31 itself is exact.
`timescale 1ns/100ps
`default_nettype none
`include "fpc_cfg.svh"

module fp_to_int import fpc_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               en,
  input  fp32_s              a,
  output logic signed [31:0] res,
  output fp_flags_s          flags
);

  logic signed [8:0] uexp;
  logic [54:0]       wide;
  logic              nxt_neg;
  logic              nxt_sat;
  logic [31:0]       nxt_mag;
  fp_flags_s         nxt_flags;
  logic              s1_en;
  logic              s1_neg;
  logic              s1_sat;
  logic [31:0]       s1_mag;
  fp_flags_s         s1_flags;

  assign uexp = $signed({1'b0, a.exp}) - 9'sd127;
  assign wide = {31'b0, 1'b1, a.man} << uexp[4:0];   // integer part above bit 23.

  always_comb begin
    nxt_neg   = a.sign;
    nxt_sat   = 1'b0;
    nxt_mag   = '0;
    nxt_flags = '0;
    if (a.exp == 8'hff && a.man != '0) begin
      nxt_neg           = 1'b1;   // nan maps to int min.
      nxt_sat           = 1'b1;
      nxt_flags.invalid = 1'b1;
    end else if (uexp >= 9'sd31) begin
      if (a.sign && uexp == 9'sd31 && a.man == '0) begin
        nxt_mag = `FPC_INT_MIN;   // negates to itself.
      end else begin
        nxt_sat           = 1'b1;
        nxt_flags.invalid = 1'b1;
      end
    end else if (uexp < 9'sd0) begin
      nxt_flags.inexact = (a.exp != '0) || (a.man != '0);
    end else begin
      nxt_mag           = wide[54:23];
      nxt_flags.inexact = |wide[22:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_en    <= 1'b0;
      s1_flags <= '0;
      flags    <= '0;
    end else begin
      s1_en <= en;
      if (en) s1_flags <= nxt_flags;
      if (s1_en) flags <= s1_flags;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s1_neg <= nxt_neg;
      s1_sat <= nxt_sat;
      s1_mag <= nxt_mag;
    end
    if (s1_en) begin
      if (s1_sat) res <= s1_neg ? `FPC_INT_MIN : `FPC_INT_MAX;
      else        res <= s1_neg ? -s1_mag : s1_mag;
    end
  end

endmodule

`default_nettype wire

//--- cvt_side.sv
// Paired conversion path beside one lane; latency matches the lane.
// A pending conversion overrides the lane result, else the lane passes through.
`timescale 1ns/100ps
`default_nettype none

module cvt_side import fpc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  lane_req_s req,
  input  lane_rsp_s lane_rsp,
  output lane_rsp_s rsp
);

  logic               cvt_go;
  logic               pend_q1;
  logic               pend_q2;
  logic signed [31:0] res_hi;
  logic signed [31:0] res_lo;
  fp_flags_s          flg_hi;
  fp_flags_s          flg_lo;

  assign cvt_go = req.valid && (req.op == fop_pcvt);

  fp_to_int u_cvt_hi (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (cvt_go),
    .a     (req.a.fv.hi),
    .res   (res_hi),
    .flags (flg_hi)
  );

  fp_to_int u_cvt_lo (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (cvt_go),
    .a     (req.a.fv.lo),
    .res   (res_lo),
    .flags (flg_lo)
  );

  // op decode follows the converters down both stages.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q1 <= 1'b0;
      pend_q2 <= 1'b0;
    end else begin
      pend_q1 <= cvt_go;
      pend_q2 <= pend_q1;
    end
  end

  always_comb begin
    rsp = lane_rsp;
    if (pend_q2) begin
      rsp.res.iv.ihi = res_hi;
      rsp.res.iv.ilo = res_lo;
      rsp.flags      = flg_hi | flg_lo;   // lane's invalid for pcvt dropped.
    end
  end

endmodule

`default_nettype wire

//--- fp_cluster.sv
// Three paired-single lanes; the conversion lane also owns float-to-int.
// No handshake: every valid request is taken and every response must be used.
`timescale 1ns/100ps
`default_nettype none
`include "fpc_cfg.svh"

module fp_cluster import fpc_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  lane_req_s req [0:`FPC_LANES-1],
  output lane_rsp_s rsp [0:`FPC_LANES-1]
);

  lane_rsp_s lane2_rsp;   // conversion lane before the merge.

  // ---------------------------------------------------------------------------
  // lanes
  // ---------------------------------------------------------------------------
  for (genvar k = 0; k < `FPC_LANES; k++) begin : g_lane
    if (k == `FPC_CVT_LANE) begin : g_cvt
      fp_lane u_lane (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req[k]),
        .rsp   (lane2_rsp)
      );
    end else begin : g_plain
      fp_lane u_lane (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req[k]),
        .rsp   (rsp[k])
      );
    end
  end

  // ---------------------------------------------------------------------------
  // conversion path
  // ---------------------------------------------------------------------------
  cvt_side u_cvt_side (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req[`FPC_CVT_LANE]),
    .lane_rsp (lane2_rsp),
    .rsp      (rsp[`FPC_CVT_LANE])
  );

endmodule

`default_nettype wire

//--- fp_cluster_assert.sv
// Checker bound into fp_cluster; expects a fixed FPC_LAT cycle latency on every lane.
// Latency and flag checks are off while rst_n is low.
`timescale 1ns/100ps
`default_nettype none
`include "fpc_cfg.svh"

module fp_cluster_assert import fpc_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input lane_req_s req [0:`FPC_LANES-1],
  input lane_rsp_s rsp [0:`FPC_LANES-1]
);

  int n_fail = 0;

  for (genvar k = 0; k < `FPC_LANES; k++) begin : g_chk
    a_lat: assert property (@(posedge clk) disable iff (!rst_n)
      req[k].valid |-> ##`FPC_LAT rsp[k].valid)
      else begin
        $error("lane %0d request gave no response after %0d cycles", k, `FPC_LAT);
        n_fail++;
      end

    a_orphan: assert property (@(posedge clk) disable iff (!rst_n)
      rsp[k].valid |-> $past(req[k].valid, `FPC_LAT))
      else begin
        $error("lane %0d response without a request", k);
        n_fail++;
      end

    a_rst: assert property (@(posedge clk) !rst_n |-> !rsp[k].valid)
      else begin
        $error("lane %0d response valid during reset", k);
        n_fail++;
      end

    // sign edits never raise a flag.
    a_sign: assert property (@(posedge clk) disable iff (!rst_n)
      (rsp[k].valid && ($past(req[k].op, `FPC_LAT) inside {fop_abs, fop_neg}))
        |-> (rsp[k].flags == '0))
      else begin
        $error("lane %0d abs or neg response has a flag set", k);
        n_fail++;
      end
  end

endmodule

bind fp_cluster fp_cluster_assert u_assert (
  .clk   (clk),
  .rst_n (rst_n),
  .req   (req),
  .rsp   (rsp)
);

`default_nettype wire

//--- fp_cluster_tb.sv
// Reads fp_cluster_cases.txt from the working directory, so run from the project root.
// File cases use one lane per cycle; random abs/neg traffic then fills all lanes.
`timescale 1ns/100ps
`default_nettype none
`include "fpc_cfg.svh"

module fp_cluster_tb import fpc_pkg::*; ();

  localparam int NRAND = 8;
  localparam int MAXC = 64;
  localparam int DRV = 5;

  typedef struct packed {
    logic [63:0] res;
    logic [1:0]  flags;
    logic [31:0] cyc;
    logic [31:0] id;
  } expect_s;

  logic        clk;
  logic        rst_n;
  lane_req_s   req [0:`FPC_LANES-1];
  lane_rsp_s   rsp [0:`FPC_LANES-1];
  expect_s     exp_q [0:`FPC_LANES-1][$];
  logic [31:0] cyc;
  logic [63:0] rnd;
  int          limit;
  int          n_err;
  int          n_chk;
  int          n_sent;
  int          n_case;
  int          c_lane [0:MAXC-1];
  int          c_op [0:MAXC-1];
  logic [63:0] c_a [0:MAXC-1];
  logic [63:0] c_b [0:MAXC-1];
  logic [63:0] c_res [0:MAXC-1];
  logic [1:0]  c_flags [0:MAXC-1];

  fp_cluster DUT (.clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp));

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [63:0] xorshift(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  // abs clears both sign bits, neg flips them.
  function automatic logic [63:0] sign_edit(input fp_op_e op, input logic [63:0] a);
    logic [63:0] signs;
    signs = 64'h8000_0000_8000_0000;
    return (op == fop_abs) ? (a & ~signs) : (a ^ signs);
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int k = 0; k < `FPC_LANES; k++) n += exp_q[k].size();
    return n;
  endfunction

  task automatic clear_reqs();
    for (int k = 0; k < `FPC_LANES; k++) req[k] = '0;
  endtask

  task automatic send(input int k, input fp_op_e op, input logic [63:0] a,
                      input logic [63:0] b, input logic [63:0] res, input logic [1:0] flags);
    expect_s e;
    req[k].valid = 1'b1;
    req[k].op    = op;
    req[k].a     = a;
    req[k].b     = b;
    e.res   = res;
    e.flags = flags;
    e.cyc   = cyc;
    e.id    = n_sent;
    exp_q[k].push_back(e);
    n_sent++;
  endtask

  task automatic check_rsp(input int k);
    expect_s e;
    if (exp_q[k].size() == 0) begin
      $display("lane %0d gave a response at %0t with nothing outstanding", k, $time);
      n_err++;
    end else begin
      e = exp_q[k].pop_front();
      n_chk++;
      assert (rsp[k].res == e.res) else begin
        $display("Mismatch at %0t: rsp[%0d].res got %h expected %h", $time, k, rsp[k].res, e.res);
        n_err++;
      end
      assert (rsp[k].flags == e.flags) else begin
        $display("Mismatch at %0t: rsp[%0d].flags got %b expected %b",
                 $time, k, rsp[k].flags, e.flags);
        n_err++;
      end
      assert (cyc == e.cyc + `FPC_LAT) else begin
        $display("lane %0d item %0d arrived in cycle %0d instead of %0d",
                 k, e.id, cyc, e.cyc + `FPC_LAT);
        n_err++;
      end
      $display("lane %0d item %0d done, %0d errors so far", k, e.id, n_err);
    end
  endtask

  // ---------------------------------------------------------------------------
  // cycle count, timeout and response sampling
  // ---------------------------------------------------------------------------
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (limit > 0 && cyc > limit) begin
      $display("timeout after %0d cycles with %0d responses missing", cyc, outstanding());
      $display("Test failed");
      $finish;
    end
  end

  always @(negedge clk) begin   // outputs settle well before the falling edge.
    for (int k = 0; k < `FPC_LANES; k++) begin
      if (rst_n && rsp[k].valid) begin
        check_rsp(k);
      end else if (!rst_n) begin
        assert (!rsp[k].valid) else begin
          $display("lane %0d shows a valid response during reset", k);
          n_err++;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  initial begin
    int               fd;
    int               code;
    int               l;
    int               o;
    logic [63:0]      a;
    logic [63:0]      b;
    logic [63:0]      r;
    logic [1:0]       f;
    logic [8*128-1:0] line;
    rst_n  = 1'b1;
    cyc    = '0;
    limit  = 0;
    n_err  = 0;
    n_chk  = 0;
    n_sent = 0;
    n_case = 0;
    rnd    = 64'd43789;
    clear_reqs();
    fd = $fopen("fp_cluster_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the cases file");
      n_err++;
    end else begin
      while (!$feof(fd) && n_case < MAXC) begin
        code = $fscanf(fd, " %d %d %h %h %h %h", l, o, a, b, r, f);
        if (code == 6) begin
          c_lane[n_case]  = l;
          c_op[n_case]    = o;
          c_a[n_case]     = a;
          c_b[n_case]     = b;
          c_res[n_case]   = r;
          c_flags[n_case] = f;
          n_case++;
        end else if (code >= 0) begin
          if (code > 0) begin
            $display("malformed line after case %0d in the cases file", n_case);
            n_err++;
          end
          code = $fgets(line, fd);   // rest of a comment line.
        end
      end
      $fclose(fd);
    end
    limit = (n_case + NRAND * `FPC_LANES) * 3 + 50;

    #DRV rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #DRV rst_n = 1'b1;

    for (int i = 0; i < n_case; i++) begin
      @(posedge clk);
      #DRV;
      clear_reqs();
      send(c_lane[i], fp_op_e'(c_op[i]), c_a[i], c_b[i], c_res[i], c_flags[i]);
    end

    for (int i = 0; i < NRAND; i++) begin
      @(posedge clk);
      #DRV;
      for (int k = 0; k < `FPC_LANES; k++) begin
        rnd = xorshift(rnd);
        a   = rnd;
        rnd = xorshift(rnd);
        if (rnd[0]) send(k, fop_abs, a, rnd, sign_edit(fop_abs, a), 2'b00);
        else        send(k, fop_neg, a, rnd, sign_edit(fop_neg, a), 2'b00);
      end
    end
    @(posedge clk);
    #DRV;
    clear_reqs();

    while (outstanding() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    n_err += DUT.u_assert.n_fail;
    $display("checked %0d of %0d responses, %0d errors, %0d assertion failures",
             n_chk, n_sent, n_err, DUT.u_assert.n_fail);
    if (n_err == 0 && n_chk == n_sent && n_case > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fp_cluster_cases.txt
# lane op(decimal) a b res (64-bit hex, hi half first) flags (hex, bit 1 invalid, bit 0 inexact)
# op: 0 min, 1 max, 2 abs, 3 neg, 4 cmplt, 5 pcvt
0 0 3f80000040000000 400000003f800000 3f8000003f800000 0
1 1 3f80000040000000 400000003f800000 4000000040000000 0
2 0 bf80000040400000 40000000c0000000 bf800000c0000000 0
0 1 bf80000040400000 40000000c0000000 4000000040400000 0
1 0 8000000000000000 0000000080000000 8000000080000000 0
2 1 8000000000000000 0000000080000000 0000000000000000 0
0 0 c0000000c0600000 bf8000003f000000 c0000000c0600000 0
2 1 7f800000ff800000 3f8000003f800000 7f8000003f800000 0
1 4 3f80000040000000 400000003f800000 ffffffff00000000 0
2 4 bf800000c0000000 c0000000bf800000 00000000ffffffff 0
0 0 7fc000013f800000 3f80000040000000 7fc000003f800000 2
1 1 3f80000040000000 400000007f800001 400000007fc00000 2
2 4 3f8000007fc00000 400000003f800000 ffffffff00000000 2
0 4 ffc0000000000000 0000000000000000 0000000000000000 2
0 5 3f80000040000000 0000000000000000 0000000000000000 2
1 5 4040000000000000 0000000000000000 0000000000000000 2
2 5 40200000c0600000 0000000000000000 00000002fffffffd 1
2 5 3f8000003f000000 0000000000000000 0000000100000000 1
2 5 4f000000cf000000 0000000000000000 7fffffff80000000 2
2 5 cf8000005f000000 0000000000000000 800000007fffffff 2
2 0 bf80000040400000 40000000c0000000 bf800000c0000000 0
2 5 7fc0000042c98000 0000000000000000 8000000000000064 3
2 1 8000000000000000 0000000080000000 0000000000000000 0
2 5 000000004b000001 0000000000000000 0000000000800001 0
2 5 80000000bf800000 0000000000000000 00000000ffffffff 0

//--- vlog.f
+incdir+.
fpc_pkg.sv
fp_lane.sv
fp_to_int.sv
cvt_side.sv
fp_cluster.sv
fp_cluster_assert.sv
fp_cluster_tb.sv

//--- Bender.yml
package:
  name: fp_cluster

export_include_dirs:
  - .

sources:
  - fpc_pkg.sv
  - fp_lane.sv
  - fp_to_int.sv
  - cvt_side.sv
  - fp_cluster.sv
  - target: test
    files:
      - fp_cluster_assert.sv
      - fp_cluster_tb.sv
